// ==== hw/mem_pkg.sv ====
package mem_pkg;

   // Main memory geometry
   localparam int DATA_W = 16;
   localparam int NUM_BANKS = 4; // Word interleaved on low address bits
   localparam int BANK_W = $clog2(NUM_BANKS);

   // Busy cycles per bank access
   localparam int DEF_MEM_LATENCY = 4;

endpackage

// ==== hw/cache_pkg.sv ====
package cache_pkg;

   localparam int ADDR_W = 16; // Word address
   localparam int DEF_INDEX_W = 8; // 256 lines

   // Request from the requester, 33 bits
   typedef struct packed {
      logic                       write;
      logic [ADDR_W-1:0]          addr;
      logic [mem_pkg::DATA_W-1:0] wdata;
   } req_word_t;

   // Response to the requester, 17 bits
   typedef struct packed {
      logic                       hit;
      logic [mem_pkg::DATA_W-1:0] rdata; // Reads only
   } rsp_word_t;

endpackage

// ==== hw/credit_fifo.sv ====
`timescale 1ns/1ps

module credit_fifo #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 4
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     in_valid,
   input  payload_t in_data,
   output logic     out_valid,
   output payload_t out_data,
   input  logic     pop,
   output logic     credit
);
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         slots [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign out_valid = (count != '0);
   assign out_data  = slots[rd_ptr];
   assign do_pop    = pop && out_valid;
   assign do_push   = in_valid && ((count != CNT_W'(DEPTH)) || do_pop); // Full push is dropped
   assign credit    = do_pop; // One credit back per freed slot

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (do_push)
         slots[wr_ptr] <= in_data;
   end

endmodule

// ==== hw/rsp_port.sv ====
`timescale 1ns/1ps

module rsp_port #(
   parameter int DEPTH = 4
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       push,
   input  cache_pkg::rsp_word_t       push_data,
   output logic                       space,
   input  logic                       rsp_credit,
   output logic                       rsp_valid,
   output logic                       rsp_hit,
   output logic [mem_pkg::DATA_W-1:0] rsp_rdata
);
   import cache_pkg::*;

   localparam int FILL_W = $clog2(DEPTH + 1);
   localparam int CRD_W  = 8; // Downstream credits held

   rsp_word_t         head;
   logic              head_valid;
   logic [FILL_W-1:0] fill;
   logic [CRD_W-1:0]  crd_cnt;

   credit_fifo #(
      .payload_t (rsp_word_t),
      .DEPTH     (DEPTH)
   ) rsp_buf (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (push),
      .in_data   (push_data),
      .out_valid (head_valid),
      .out_data  (head),
      .pop       (rsp_valid),
      .credit    ()
   );

   assign space     = (fill != FILL_W'(DEPTH));
   assign rsp_valid = head_valid && (crd_cnt != '0); // Send only with a credit
   assign rsp_hit   = head.hit;
   assign rsp_rdata = head.rdata;

   always_ff @(posedge clk) begin
      if (rst) begin
         fill    <= '0;
         crd_cnt <= '0;
      end else begin
         case ({push, rsp_valid})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
         case ({rsp_credit, rsp_valid})
            2'b10:   crd_cnt <= crd_cnt + 1'b1;
            2'b01:   crd_cnt <= crd_cnt - 1'b1;
            default: crd_cnt <= crd_cnt;
         endcase
      end
   end

endmodule

// ==== hw/cache_array.sv ====
`timescale 1ns/1ps

module cache_array #(
   parameter int INDEX_W = cache_pkg::DEF_INDEX_W
) (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  en,
   input  logic                                  comp,
   input  logic                                  cache_wr,
   input  logic [INDEX_W-1:0]                    index,
   input  logic [cache_pkg::ADDR_W-INDEX_W-1:0]  tag,
   input  logic [mem_pkg::DATA_W-1:0]            wdata,
   output logic                                  hit,
   output logic                                  dirty,
   output logic                                  valid,
   output logic [cache_pkg::ADDR_W-INDEX_W-1:0]  tag_out,
   output logic [mem_pkg::DATA_W-1:0]            rdata
);
   import cache_pkg::*;
   import mem_pkg::*;

   localparam int TAG_W = ADDR_W - INDEX_W;
   localparam int LINES = 2 ** INDEX_W;

   logic [TAG_W-1:0]  tag_mem  [LINES];
   logic [DATA_W-1:0] data_mem [LINES];
   logic [LINES-1:0]  valid_q;
   logic [LINES-1:0]  dirty_q;
   logic              line_wr;

   assign line_wr = en && cache_wr;

   // Lookup is purely combinational
   assign valid   = valid_q[index];
   assign dirty   = dirty_q[index];
   assign tag_out = tag_mem[index];
   assign rdata   = data_mem[index];
   assign hit     = comp && (tag_mem[index] == tag);

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (line_wr) begin
         valid_q[index] <= 1'b1;
         dirty_q[index] <= comp; // Processor write dirties, fill is clean
      end
   end

   always_ff @(posedge clk) begin
      if (line_wr) begin
         tag_mem[index]  <= tag;
         data_mem[index] <= wdata;
      end
   end

endmodule

// ==== hw/banked_mem.sv ====
`timescale 1ns/1ps

module banked_mem #(
   parameter int LATENCY = mem_pkg::DEF_MEM_LATENCY
) (
   input  logic                          clk,
   input  logic                          mem_rd,
   input  logic                          mem_wr,
   input  logic [cache_pkg::ADDR_W-1:0]  addr,
   input  logic [mem_pkg::DATA_W-1:0]    wdata,
   output logic [mem_pkg::NUM_BANKS-1:0] busy,
   output logic [mem_pkg::DATA_W-1:0]    rdata
);
   import cache_pkg::*;
   import mem_pkg::*;

   localparam int ROW_W = ADDR_W - BANK_W;
   localparam int ROWS  = 2 ** ROW_W;
   localparam int CNT_W = $clog2(LATENCY + 1);

   logic [DATA_W-1:0] bank_mem [NUM_BANKS][ROWS];
   logic [CNT_W-1:0]  cnt      [NUM_BANKS];
   logic              op_wr    [NUM_BANKS];
   logic [ROW_W-1:0]  row_q    [NUM_BANKS];
   logic [DATA_W-1:0] wdata_q  [NUM_BANKS];
   logic [BANK_W-1:0] sel_bank;
   logic [ROW_W-1:0]  sel_row;

   assign sel_bank = addr[BANK_W-1:0];
   assign sel_row  = addr[ADDR_W-1:BANK_W];

   // Contents start at zero, reset leaves them alone
   initial begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         cnt[b] = '0;
         for (int r = 0; r < ROWS; r++)
            bank_mem[b][r] = '0;
      end
      rdata = '0;
   end

   always_comb begin
      for (int b = 0; b < NUM_BANKS; b++)
         busy[b] = (cnt[b] != '0);
   end

   always @(posedge clk) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         if (cnt[b] != '0) begin
            cnt[b] <= cnt[b] - 1'b1;
            if (cnt[b] == CNT_W'(1)) begin // Access completes as busy drops
               if (op_wr[b])
                  bank_mem[b][row_q[b]] <= wdata_q[b];
               else
                  rdata <= bank_mem[b][row_q[b]];
            end
         end else if ((mem_rd || mem_wr) && (sel_bank == BANK_W'(b))) begin
            cnt[b]     <= CNT_W'(LATENCY);
            op_wr[b]   <= mem_wr;
            row_q[b]   <= sel_row;
            wdata_q[b] <= wdata;
         end
      end
   end

endmodule

// ==== hw/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl #(
   parameter int INDEX_W = cache_pkg::DEF_INDEX_W
) (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic                                 req_head_valid,
   input  cache_pkg::req_word_t                 req_head,
   output logic                                 req_pop,
   input  logic                                 rsp_space,
   output logic                                 rsp_push,
   output cache_pkg::rsp_word_t                 rsp_data,
   output logic                                 en,
   output logic                                 comp,
   output logic                                 cache_wr,
   output logic [INDEX_W-1:0]                   index,
   output logic [cache_pkg::ADDR_W-INDEX_W-1:0] tag,
   output logic [mem_pkg::DATA_W-1:0]           cache_wdata,
   input  logic                                 hit,
   input  logic                                 dirty,
   input  logic                                 valid,
   input  logic [cache_pkg::ADDR_W-INDEX_W-1:0] cache_tag,
   input  logic [mem_pkg::DATA_W-1:0]           cache_rdata,
   output logic                                 mem_rd,
   output logic                                 mem_wr,
   output logic [cache_pkg::ADDR_W-1:0]         mem_addr,
   output logic [mem_pkg::DATA_W-1:0]           mem_wdata,
   input  logic [mem_pkg::NUM_BANKS-1:0]        busy,
   input  logic [mem_pkg::DATA_W-1:0]           mem_rdata,
   output logic                                 err
);
   import cache_pkg::*;

   localparam int TAG_W = ADDR_W - INDEX_W;

   typedef enum logic [3:0] {
      IDLE      = 4'b0000,
      ACCESS_RD = 4'b0011, // Victim check, start write-back or fill
      MEM_WR    = 4'b0100,
      MEM_RD    = 4'b0101,
      ACCESS_WR = 4'b0110
   } state_t;

   state_t           state;
   state_t           nxt_state;
   req_word_t        req_q;
   req_word_t        cur;
   logic [TAG_W-1:0] vic_tag_q;
   logic             hit_q;
   logic             accept;
   logic             fill_sel;

   assign accept = (state == IDLE) && req_head_valid && rsp_space;

   // Array sees the live head in IDLE, the held request otherwise
   assign cur         = (state == IDLE) ? req_head : req_q;
   assign index       = cur.addr[INDEX_W-1:0];
   assign tag         = cur.addr[ADDR_W-1:INDEX_W];
   assign cache_wdata = fill_sel ? mem_rdata : cur.wdata;
   assign mem_wdata   = cache_rdata; // Victim word

   always_ff @(posedge clk) begin
      if (rst)
         state <= IDLE;
      else
         state <= nxt_state;
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         req_q     <= req_head;
         vic_tag_q <= cache_tag;
         hit_q     <= hit && valid;
      end
   end

   always_comb begin
      nxt_state      = state;
      req_pop        = 1'b0;
      rsp_push       = 1'b0;
      rsp_data.hit   = hit_q;
      rsp_data.rdata = cache_rdata;
      en             = 1'b0;
      comp           = 1'b0;
      cache_wr       = 1'b0;
      fill_sel       = 1'b0;
      mem_rd         = 1'b0;
      mem_wr         = 1'b0;
      mem_addr       = req_q.addr;
      err            = 1'b0;

      case (state)
         IDLE: begin
            if (accept) begin
               en   = 1'b1;
               comp = 1'b1;
               if (hit && valid) begin // Done in one cycle
                  cache_wr     = req_head.write;
                  req_pop      = 1'b1;
                  rsp_push     = 1'b1;
                  rsp_data.hit = 1'b1;
               end else begin
                  nxt_state = ACCESS_RD;
               end
            end
         end
         ACCESS_RD: begin
            en = 1'b1;
            if (dirty) begin
               mem_wr    = 1'b1;
               mem_addr  = {vic_tag_q, req_q.addr[INDEX_W-1:0]}; // Rebuilt victim address
               nxt_state = MEM_WR;
            end else begin
               mem_rd    = 1'b1;
               nxt_state = MEM_RD;
            end
         end
         MEM_WR: begin
            if (busy == '0) begin // Write-back done, fetch the new word
               mem_rd    = 1'b1;
               nxt_state = MEM_RD;
            end
         end
         MEM_RD: begin
            if (busy == '0) begin
               en        = 1'b1;
               cache_wr  = 1'b1;
               fill_sel  = 1'b1;
               nxt_state = ACCESS_WR;
            end
         end
         ACCESS_WR: begin
            en        = 1'b1;
            comp      = 1'b1;
            cache_wr  = req_q.write; // Write miss merges its data after fill
            req_pop   = 1'b1;
            rsp_push  = 1'b1;
            nxt_state = IDLE;
         end
         default: begin
            err       = 1'b1;
            nxt_state = IDLE;
         end
      endcase
   end

endmodule

// ==== hw/cache_sys.sv ====
`timescale 1ns/1ps

module cache_sys #(
   parameter int INDEX_W     = cache_pkg::DEF_INDEX_W,
   parameter int REQ_DEPTH   = 4,
   parameter int RSP_DEPTH   = 4,
   parameter int MEM_LATENCY = mem_pkg::DEF_MEM_LATENCY
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         req_valid,
   input  logic                         req_write,
   input  logic [cache_pkg::ADDR_W-1:0] req_addr,
   input  logic [mem_pkg::DATA_W-1:0]   req_wdata,
   output logic                         req_credit,
   output logic                         rsp_valid,
   output logic                         rsp_hit,
   output logic [mem_pkg::DATA_W-1:0]   rsp_rdata,
   input  logic                         rsp_credit,
   output logic                         err
);
   import cache_pkg::*;
   import mem_pkg::*;

   localparam int TAG_W = ADDR_W - INDEX_W;

   req_word_t             req_in;
   req_word_t             req_head;
   logic                  req_head_valid;
   logic                  req_pop;
   rsp_word_t             rsp_data;
   logic                  rsp_push;
   logic                  rsp_space;
   logic                  en;
   logic                  comp;
   logic                  cache_wr;
   logic [INDEX_W-1:0]    index;
   logic [TAG_W-1:0]      tag;
   logic [DATA_W-1:0]     cache_wdata;
   logic                  hit;
   logic                  dirty;
   logic                  valid;
   logic [TAG_W-1:0]      cache_tag;
   logic [DATA_W-1:0]     cache_rdata;
   logic                  mem_rd;
   logic                  mem_wr;
   logic [ADDR_W-1:0]     mem_addr;
   logic [DATA_W-1:0]     mem_wdata;
   logic [NUM_BANKS-1:0]  busy;
   logic [DATA_W-1:0]     mem_rdata;

   assign req_in = '{write: req_write, addr: req_addr, wdata: req_wdata};

   credit_fifo #(
      .payload_t (req_word_t),
      .DEPTH     (REQ_DEPTH)
   ) req_buf (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (req_valid),
      .in_data   (req_in),
      .out_valid (req_head_valid),
      .out_data  (req_head),
      .pop       (req_pop),
      .credit    (req_credit)
   );

   cache_ctrl #(
      .INDEX_W (INDEX_W)
   ) u_ctrl (
      .clk            (clk),
      .rst            (rst),
      .req_head_valid (req_head_valid),
      .req_head       (req_head),
      .req_pop        (req_pop),
      .rsp_space      (rsp_space),
      .rsp_push       (rsp_push),
      .rsp_data       (rsp_data),
      .en             (en),
      .comp           (comp),
      .cache_wr       (cache_wr),
      .index          (index),
      .tag            (tag),
      .cache_wdata    (cache_wdata),
      .hit            (hit),
      .dirty          (dirty),
      .valid          (valid),
      .cache_tag      (cache_tag),
      .cache_rdata    (cache_rdata),
      .mem_rd         (mem_rd),
      .mem_wr         (mem_wr),
      .mem_addr       (mem_addr),
      .mem_wdata      (mem_wdata),
      .busy           (busy),
      .mem_rdata      (mem_rdata),
      .err            (err)
   );

   cache_array #(
      .INDEX_W (INDEX_W)
   ) u_array (
      .clk      (clk),
      .rst      (rst),
      .en       (en),
      .comp     (comp),
      .cache_wr (cache_wr),
      .index    (index),
      .tag      (tag),
      .wdata    (cache_wdata),
      .hit      (hit),
      .dirty    (dirty),
      .valid    (valid),
      .tag_out  (cache_tag),
      .rdata    (cache_rdata)
   );

   banked_mem #(
      .LATENCY (MEM_LATENCY)
   ) u_mem (
      .clk    (clk),
      .mem_rd (mem_rd),
      .mem_wr (mem_wr),
      .addr   (mem_addr),
      .wdata  (mem_wdata),
      .busy   (busy),
      .rdata  (mem_rdata)
   );

   rsp_port #(
      .DEPTH (RSP_DEPTH)
   ) u_rsp (
      .clk        (clk),
      .rst        (rst),
      .push       (rsp_push),
      .push_data  (rsp_data),
      .space      (rsp_space),
      .rsp_credit (rsp_credit),
      .rsp_valid  (rsp_valid),
      .rsp_hit    (rsp_hit),
      .rsp_rdata  (rsp_rdata)
   );

endmodule

// ==== test/cache_sys_chk.sv ====
`timescale 1ns/1ps

module cache_sys_chk #(
   parameter int REQ_DEPTH = 4
) (
   input logic clk,
   input logic rst,
   input logic err,
   input logic req_valid,
   input logic req_credit,
   input logic rsp_valid,
   input logic rsp_credit,
   input logic mem_rd,
   input logic mem_wr
);
   int held; // Response credits granted, not yet spent
   int fill; // Request buffer occupancy
   int fire_count = 0;

   always_ff @(posedge clk) begin
      if (rst) begin
         held <= 0;
         fill <= 0;
      end else begin
         held <= held + int'(rsp_credit) - int'(rsp_valid);
         fill <= fill + int'(req_valid) - int'(req_credit);
      end
   end

   no_err: assert property (@(posedge clk) disable iff (rst) !err)
      else begin
         $error("controller reached an illegal state");
         fire_count++;
      end

   rsp_needs_credit: assert property (@(posedge clk) disable iff (rst) rsp_valid |-> held > 0)
      else begin
         $error("response sent with no credit held");
         fire_count++;
      end

   req_no_overflow: assert property (@(posedge clk) disable iff (rst)
         !(req_valid && !req_credit && fill >= REQ_DEPTH))
      else begin
         $error("request pushed into a full buffer");
         fire_count++;
      end

   mem_one_op: assert property (@(posedge clk) disable iff (rst) !(mem_rd && mem_wr))
      else begin
         $error("memory read and write issued together");
         fire_count++;
      end

endmodule

bind cache_sys cache_sys_chk #(
   .REQ_DEPTH (REQ_DEPTH)
) chk (
   .clk        (clk),
   .rst        (rst),
   .err        (err),
   .req_valid  (req_valid),
   .req_credit (req_credit),
   .rsp_valid  (rsp_valid),
   .rsp_credit (rsp_credit),
   .mem_rd     (mem_rd),
   .mem_wr     (mem_wr)
);

// ==== test/cache_sys_tb.sv ====
`timescale 1ns/1ps

module cache_sys_tb;
   import cache_pkg::*;
   import mem_pkg::*;

   localparam int INDEX_W       = 8;
   localparam int REQ_DEPTH     = 4;
   localparam int RSP_DEPTH     = 4;
   localparam int MEM_LATENCY   = 4;
   localparam int CLK_PERIOD    = 20;
   localparam int TABLE_LEN     = 21;
   localparam int NUM_RANDOM    = 200;
   localparam int REQ_CYCLES    = 2 * MEM_LATENCY + 4; // Rough cycles per request
   localparam int SETTLE_CYCLES = 4 * REQ_CYCLES;
   localparam int WATCHDOG_NS   = 2 * (TABLE_LEN + NUM_RANDOM) * REQ_CYCLES * CLK_PERIOD + 20000;
   localparam logic [31:0] SEED = 32'h826e_a727;
   localparam logic [7:0] IDX_SET [4] = '{8'h10, 8'h33, 8'h40, 8'h7e};
   localparam logic [7:0] TAG_SET [4] = '{8'h00, 8'h05, 8'h12, 8'hc1};

   logic              clk;
   logic              rst;
   logic              req_valid;
   logic              req_write;
   logic [ADDR_W-1:0] req_addr;
   logic [DATA_W-1:0] req_wdata;
   logic              req_credit;
   logic              rsp_valid;
   logic              rsp_hit;
   logic [DATA_W-1:0] rsp_rdata;
   logic              rsp_credit;
   logic              err;

   // Stimulus table with hand-derived expected responses
   logic              tbl_write [TABLE_LEN];
   logic [ADDR_W-1:0] tbl_addr  [TABLE_LEN];
   logic [DATA_W-1:0] tbl_data  [TABLE_LEN];
   logic              tbl_hold  [TABLE_LEN];
   logic              tbl_hit   [TABLE_LEN];
   logic [DATA_W-1:0] tbl_rdata [TABLE_LEN];
   int                tbl_n = 0;

   // Reference model
   logic [DATA_W-1:0]         ref_mem   [65536];
   logic [ADDR_W-INDEX_W-1:0] ref_tag   [2**INDEX_W];
   logic                      ref_valid [2**INDEX_W];

   int                exp_id_q   [$]; // Responses return in request order
   logic              exp_hit_q  [$];
   logic [DATA_W-1:0] exp_data_q [$];
   logic              exp_rd_q   [$];

   int   credits = REQ_DEPTH; // Request credits held by the requester
   int   held = 0; // Response credits granted, not yet used
   logic hold = 1'b0;
   int   hold_rsp = 0;
   int   err_count = 0;
   int   pass_count = 0;
   int   fail_count = 0;
   int   rnd_errors = 0;

   cache_sys #(
      .INDEX_W     (INDEX_W),
      .REQ_DEPTH   (REQ_DEPTH),
      .RSP_DEPTH   (RSP_DEPTH),
      .MEM_LATENCY (MEM_LATENCY)
   ) DUT (
      .clk        (clk),
      .rst        (rst),
      .req_valid  (req_valid),
      .req_write  (req_write),
      .req_addr   (req_addr),
      .req_wdata  (req_wdata),
      .req_credit (req_credit),
      .rsp_valid  (rsp_valid),
      .rsp_hit    (rsp_hit),
      .rsp_rdata  (rsp_rdata),
      .rsp_credit (rsp_credit),
      .err        (err)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns with requests still outstanding", WATCHDOG_NS);
      $display("SIMULATION FAILED");
      $finish;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic add_entry(input logic write, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data, input logic hold_crd,
                            input logic hit_e, input logic [DATA_W-1:0] rdata_e);
      tbl_write[tbl_n] = write;
      tbl_addr[tbl_n]  = addr;
      tbl_data[tbl_n]  = data;
      tbl_hold[tbl_n]  = hold_crd;
      tbl_hit[tbl_n]   = hit_e;
      tbl_rdata[tbl_n] = rdata_e;
      tbl_n++;
   endtask

   // Hit when the index holds this tag, then the index takes the tag
   task automatic model_access(input logic write, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] data, output logic hit_e,
                               output logic [DATA_W-1:0] rdata_e);
      logic [INDEX_W-1:0] idx;
      idx = addr[INDEX_W-1:0];
      hit_e = ref_valid[idx] && (ref_tag[idx] == addr[ADDR_W-1:INDEX_W]);
      ref_valid[idx] = 1'b1;
      ref_tag[idx]   = addr[ADDR_W-1:INDEX_W];
      if (write)
         ref_mem[addr] = data;
      rdata_e = ref_mem[addr];
   endtask

   task automatic check_response();
      int                id;
      logic              hit_e;
      logic [DATA_W-1:0] data_e;
      logic              rd;
      logic              ok;
      if (exp_id_q.size() == 0) begin
         $display("response arrived at %0t ns with no request outstanding", $time);
         err_count++;
      end else begin
         id     = exp_id_q.pop_front();
         hit_e  = exp_hit_q.pop_front();
         data_e = exp_data_q.pop_front();
         rd     = exp_rd_q.pop_front();
         ok = (rsp_hit === hit_e) && (!rd || (rsp_rdata === data_e));
         if (!ok) begin
            $display("FAIL %0t: request %0d gave hit %0b data %h, expected hit %0b data %h",
                     $time, id, rsp_hit, rsp_rdata, hit_e, data_e);
            err_count++;
         end
         if (id < TABLE_LEN) begin
            if (ok) begin
               pass_count++;
               $display("test %0d ok: hit %0b data %h", id, rsp_hit, rsp_rdata);
            end else begin
               fail_count++;
            end
         end else if (!ok) begin
            rnd_errors++;
         end
      end
   endtask

   // Samples the cycle's outputs at the falling edge, then drives its inputs
   task automatic cycle(input logic want, input logic write, input logic [ADDR_W-1:0] addr,
                        input logic [DATA_W-1:0] data, input int id, input logic hit_e,
                        input logic [DATA_W-1:0] rdata_e, input logic rd, output logic sent);
      @(negedge clk);
      if (rsp_valid) begin
         if (hold)
            hold_rsp++;
         check_response();
         held--;
      end
      if (req_credit)
         credits++;
      if (credits > REQ_DEPTH) begin
         $display("request credit count rose above %0d at %0t ns", REQ_DEPTH, $time);
         err_count++;
      end
      sent = want && (credits > 0);
      req_valid = sent;
      req_write = write;
      req_addr  = addr;
      req_wdata = data;
      if (sent) begin
         credits--;
         exp_id_q.push_back(id);
         exp_hit_q.push_back(hit_e);
         exp_data_q.push_back(rdata_e);
         exp_rd_q.push_back(rd);
      end
      rsp_credit = !hold && (held < exp_id_q.size()); // Never more credits than pending
      if (rsp_credit)
         held++;
   endtask

   task automatic idle();
      logic sent;
      cycle(1'b0, 1'b0, '0, '0, 0, 1'b0, '0, 1'b0, sent);
   endtask

   task automatic send(input logic write, input logic [ADDR_W-1:0] addr,
                       input logic [DATA_W-1:0] data, input int id, input logic hit_e,
                       input logic [DATA_W-1:0] rdata_e);
      logic sent;
      sent = 1'b0;
      while (!sent)
         cycle(1'b1, write, addr, data, id, hit_e, rdata_e, !write, sent);
   endtask

   task automatic drain();
      while (exp_id_q.size() != 0)
         idle();
   endtask

   task automatic check_backpressure();
      repeat (SETTLE_CYCLES)
         idle();
      if ((credits == 0) && (hold_rsp == 0)) begin
         pass_count++;
         $display("back-pressure ok: request credits used up, no response without credit");
      end else begin
         fail_count++;
         err_count++;
         $display("back-pressure broken: %0d request credits left, %0d responses while held",
                  credits, hold_rsp);
      end
   endtask

   initial begin
      logic              hit_e;
      logic [DATA_W-1:0] rdata_e;
      logic [31:0]       rnd;
      logic [ADDR_W-1:0] addr;
      logic              nxt_hold;
      int                fires;
      rst        = 1'b1;
      req_valid  = 1'b0;
      req_write  = 1'b0;
      req_addr   = '0;
      req_wdata  = '0;
      rsp_credit = 1'b0;
      for (int a = 0; a < 65536; a++)
         ref_mem[a] = '0;
      for (int i = 0; i < 2**INDEX_W; i++) begin
         ref_tag[i]   = '0;
         ref_valid[i] = 1'b0;
      end

      add_entry(0, 16'h0010, 16'h0000, 0, 0, 16'h0000); // Cold reads
      add_entry(0, 16'h1234, 16'h0000, 0, 0, 16'h0000);
      add_entry(0, 16'hffff, 16'h0000, 0, 0, 16'h0000);
      add_entry(1, 16'h0020, 16'hbeef, 0, 0, 16'h0000); // Write allocate, then hits
      add_entry(0, 16'h0020, 16'h0000, 0, 1, 16'hbeef);
      add_entry(1, 16'h0020, 16'h1111, 0, 1, 16'h0000);
      add_entry(0, 16'h0020, 16'h0000, 0, 1, 16'h1111);
      add_entry(1, 16'h0130, 16'ha5a5, 0, 0, 16'h0000); // Dirty victim on index 0x30
      add_entry(0, 16'h0230, 16'h0000, 0, 0, 16'h0000);
      add_entry(0, 16'h0130, 16'h0000, 0, 0, 16'ha5a5);
      add_entry(1, 16'h0340, 16'h0101, 1, 0, 16'h0000); // Response credits withheld
      add_entry(0, 16'h0440, 16'h0000, 1, 0, 16'h0000);
      add_entry(1, 16'h0540, 16'h0202, 1, 0, 16'h0000);
      add_entry(0, 16'h0340, 16'h0000, 1, 0, 16'h0101);
      add_entry(0, 16'h0010, 16'h0000, 1, 1, 16'h0000);
      add_entry(1, 16'h1234, 16'h3c3c, 1, 1, 16'h0000);
      add_entry(0, 16'h1234, 16'h0000, 1, 1, 16'h3c3c);
      add_entry(0, 16'h0540, 16'h0000, 1, 0, 16'h0202);
      add_entry(0, 16'hffff, 16'h0000, 0, 1, 16'h0000);
      add_entry(0, 16'h0440, 16'h0000, 0, 0, 16'h0000);
      add_entry(0, 16'h0020, 16'h0000, 0, 1, 16'h1111);

      repeat (4)
         @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      for (int i = 0; i < TABLE_LEN; i++) begin
         if (tbl_hold[i] && !hold) begin
            drain(); // Start the held run with no credits outstanding
            hold = 1'b1;
         end
         model_access(tbl_write[i], tbl_addr[i], tbl_data[i], hit_e, rdata_e);
         send(tbl_write[i], tbl_addr[i], tbl_data[i], i, tbl_hit[i], tbl_rdata[i]);
         nxt_hold = (i + 1 < TABLE_LEN) ? tbl_hold[i + 1] : 1'b0;
         if (hold && !nxt_hold) begin
            check_backpressure();
            hold = 1'b0;
         end
      end
      drain();

      rnd = SEED;
      for (int n = 0; n < NUM_RANDOM; n++) begin
         rnd  = xorshift(rnd);
         addr = {TAG_SET[rnd[3:2]], IDX_SET[rnd[1:0]]}; // Few lines, many conflicts
         model_access(rnd[8], addr, rnd[31:16], hit_e, rdata_e);
         send(rnd[8], addr, rnd[31:16], TABLE_LEN + n, hit_e, rdata_e);
      end
      drain();
      $display("random: %0d requests, %0d mismatches", NUM_RANDOM, rnd_errors);
      if (rnd_errors == 0)
         pass_count++;
      else
         fail_count++;

      repeat (SETTLE_CYCLES)
         idle();
      if (credits == REQ_DEPTH) begin
         pass_count++;
         $display("credits ok: %0d of %0d back when idle", credits, REQ_DEPTH);
      end else begin
         fail_count++;
         err_count++;
         $display("requester holds %0d credits when idle instead of %0d", credits, REQ_DEPTH);
      end

      fires = DUT.chk.fire_count;
      if (fires == 0) begin
         pass_count++;
         $display("bound assertions ok");
      end else begin
         fail_count++;
         err_count++;
         $display("bound assertions failed %0d times", fires);
      end

      $display("tests: %0d passed, %0d failed, %0d errors", pass_count, fail_count, err_count);
      if ((err_count == 0) && (fail_count == 0))
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// ==== cache_sys.f ====
hw/mem_pkg.sv
hw/cache_pkg.sv
hw/credit_fifo.sv
hw/rsp_port.sv
hw/cache_array.sv
hw/banked_mem.sv
hw/cache_ctrl.sv
hw/cache_sys.sv
test/cache_sys_chk.sv
test/cache_sys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cache_sys testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   --top-module cache_sys_tb -f cache_sys.f -o cache_sys_sim

status=0
./obj_dir/cache_sys_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
   exit "$status"
fi
grep -q "^SIMULATION PASSED$" sim.log
